// File: hw/exec_pkg.sv
// Execute stage definitions
package exec_pkg;

	localparam int xlen = 64;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// op_nop first so that a cleared register decodes as a bubble
	typedef enum logic [5:0]
	{
		op_nop,
		op_add, op_sub, op_sll, op_srl, op_sra,
		op_slt, op_sltu, op_xor, op_or, op_and,
		op_addi, op_slli, op_srli, op_srai,
		op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_addw, op_subw, op_sllw, op_srlw, op_sraw,
		op_addiw, op_slliw, op_srliw, op_sraiw,
		op_lui, op_auipc,
		op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw,
		op_div, op_divu, op_rem, op_remu,
		op_divw, op_divuw, op_remw, op_remuw,
		op_pass // Loads, stores, branches, jumps, fence, system
	} exec_op_t;

	function automatic logic op_is_muldiv(input exec_op_t op);
		return op inside {op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw,
			op_div, op_divu, op_rem, op_remu,
			op_divw, op_divuw, op_remw, op_remuw};
	endfunction

	function automatic logic op_writes_rd(input exec_op_t op);
		return !(op inside {op_pass, op_nop});
	endfunction

endpackage

// File: hw/stage_if.sv
// Issue bundle from decode
`timescale 1ns/100ps

interface stage_if;
	import exec_pkg::*;

	logic decode_en; // One cycle per instruction
	reg_addr_t rd;
	word rs1_val;
	word rs2_val;
	word imm;
	exec_op_t op;
	word pc;

	modport issue
	(
		output decode_en,
		output rd,
		output rs1_val,
		output rs2_val,
		output imm,
		output op,
		output pc
	);

	modport sink
	(
		input decode_en,
		input rd,
		input rs1_val,
		input rs2_val,
		input imm,
		input op,
		input pc
	);

endinterface

// File: hw/int_alu.sv
// Integer ALU
`timescale 1ns/100ps

module int_alu
(
	stage_if.sink issue,
	output exec_pkg::word result
);
	import exec_pkg::*;

	word opa;
	word opb;
	logic [31:0] res_w;
	logic is_word;

	assign opa = issue.rs1_val;
	assign opb = (issue.op inside {op_addi, op_slli, op_srli, op_srai, op_slti, op_sltiu,
		op_xori, op_ori, op_andi, op_addiw, op_slliw, op_srliw, op_sraiw}) ?
		issue.imm : issue.rs2_val; // Immediate forms

	always_comb
	begin
		res_w = '0;
		is_word = 1'b0;
		result = '0;
		case (issue.op)
			op_add, op_addi: result = opa + opb;
			op_sub: result = opa - opb;
			op_sll, op_slli: result = opa << opb[5:0];
			op_srl, op_srli: result = opa >> opb[5:0];
			op_sra, op_srai: result = word'($signed(opa) >>> opb[5:0]);
			op_slt, op_slti: result = word'($signed(opa) < $signed(opb));
			op_sltu, op_sltiu: result = word'(opa < opb);
			op_xor, op_xori: result = opa ^ opb;
			op_or, op_ori: result = opa | opb;
			op_and, op_andi: result = opa & opb;
			op_lui: result = issue.imm; // Decode already shifted it
			op_auipc: result = issue.pc + issue.imm;
			op_addw, op_addiw:
			begin
				res_w = opa[31:0] + opb[31:0];
				is_word = 1'b1;
			end
			op_subw:
			begin
				res_w = opa[31:0] - opb[31:0];
				is_word = 1'b1;
			end
			op_sllw, op_slliw:
			begin
				res_w = opa[31:0] << opb[4:0];
				is_word = 1'b1;
			end
			op_srlw, op_srliw:
			begin
				res_w = opa[31:0] >> opb[4:0];
				is_word = 1'b1;
			end
			op_sraw, op_sraiw:
			begin
				res_w = $signed(opa[31:0]) >>> opb[4:0];
				is_word = 1'b1;
			end
			default: result = '0; // Mul/div, pass and nop
		endcase
		if (is_word)
			result = {{32{res_w[31]}}, res_w};
	end

endmodule

// File: hw/mul_div_unit.sv
// Multiply and divide unit
`timescale 1ns/100ps

module mul_div_unit
(
	stage_if.sink issue,
	output exec_pkg::word result
);
	import exec_pkg::*;

	logic is_word;
	logic is_unsigned;
	logic a_signed;
	logic b_signed;
	logic [2*xlen-1:0] product;
	word da;
	word db;
	word db_safe;
	word q_raw;
	word r_raw;
	word quot;
	word rem;
	word wide_res;
	logic div_zero;
	logic div_ovf;

	assign is_word = issue.op inside {op_mulw, op_divw, op_divuw, op_remw, op_remuw};
	assign is_unsigned = issue.op inside {op_divu, op_remu, op_divuw, op_remuw};
	assign a_signed = issue.op inside {op_mulh, op_mulhsu};
	assign b_signed = (issue.op == op_mulh);

	// Low 128 bits of the extended operands give every product form
	assign product = {{xlen{a_signed & issue.rs1_val[xlen-1]}}, issue.rs1_val} *
		{{xlen{b_signed & issue.rs2_val[xlen-1]}}, issue.rs2_val};

	// Word divides run on extended 32-bit operands
	always_comb
	begin
		da = issue.rs1_val;
		db = issue.rs2_val;
		if (is_word)
		begin
			da = is_unsigned ? {32'b0, issue.rs1_val[31:0]} :
				{{32{issue.rs1_val[31]}}, issue.rs1_val[31:0]};
			db = is_unsigned ? {32'b0, issue.rs2_val[31:0]} :
				{{32{issue.rs2_val[31]}}, issue.rs2_val[31:0]};
		end
	end

	assign div_zero = (db == '0);
	assign div_ovf = !is_unsigned && (da == {1'b1, {(xlen-1){1'b0}}}) && (db == {xlen{1'b1}});
	assign db_safe = (div_zero || div_ovf) ? word'(1) : db; // Keeps divider defined
	assign q_raw = is_unsigned ? da / db_safe : word'($signed(da) / $signed(db_safe));
	assign r_raw = is_unsigned ? da % db_safe : word'($signed(da) % $signed(db_safe));
	assign quot = div_zero ? {xlen{1'b1}} : (div_ovf ? da : q_raw);
	assign rem = div_zero ? da : (div_ovf ? '0 : r_raw);

	always_comb
	begin
		case (issue.op)
			op_mul, op_mulw: wide_res = product[xlen-1:0];
			op_mulh, op_mulhsu, op_mulhu: wide_res = product[2*xlen-1:xlen];
			op_div, op_divu, op_divw, op_divuw: wide_res = quot;
			op_rem, op_remu, op_remw, op_remuw: wide_res = rem;
			default: wide_res = '0;
		endcase
	end

	assign result = is_word ? {{32{wide_res[31]}}, wide_res[31:0]} : wide_res;

	always_comb
	begin
		if (issue.decode_en && op_is_muldiv(issue.op))
			assert final (!$isunknown(result))
			else $error("Unknown mul/div result for %s", issue.op.name());
	end

endmodule

// File: hw/execute_stage.sv
// Execute stage and stage-3 register
`timescale 1ns/100ps

module execute_stage
(
	input logic clk,
	input logic rst,
	stage_if.sink issue,
	output logic result_valid,
	output logic wr_en,
	output exec_pkg::word alu_result,
	output exec_pkg::word rs2_val_out,
	output exec_pkg::reg_addr_t rd_out,
	output exec_pkg::word pc_out,
	output exec_pkg::exec_op_t op_out
);
	import exec_pkg::*;

	word alu_res;
	word md_res;
	word unit_res;
	logic writes;

	int_alu u_int_alu
	(
		.issue(issue),
		.result(alu_res)
	);

	mul_div_unit u_mul_div_unit
	(
		.issue(issue),
		.result(md_res)
	);

	assign unit_res = op_is_muldiv(issue.op) ? md_res : alu_res;
	assign writes = op_writes_rd(issue.op);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result_valid <= 1'b0;
			wr_en <= 1'b0;
			alu_result <= '0;
			rs2_val_out <= '0;
			rd_out <= '0;
			pc_out <= '0;
			op_out <= op_nop;
		end
		else
		begin
			result_valid <= issue.decode_en;
			wr_en <= issue.decode_en && writes;
			if (issue.decode_en) // Data holds across idle cycles
			begin
				alu_result <= unit_res;
				rs2_val_out <= issue.rs2_val; // Store data for the memory stage
				rd_out <= issue.rd;
				pc_out <= issue.pc;
				op_out <= issue.op;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) wr_en |-> result_valid);
	assert property (@(posedge clk) rst |=> !result_valid && !wr_en);

endmodule

// File: hw/exec_top.sv
// Execute stage top level
`timescale 1ns/100ps

module exec_top
(
	input logic clk,
	input logic rst,
	input logic decode_en,
	input exec_pkg::reg_addr_t rd,
	input exec_pkg::word rs1_val,
	input exec_pkg::word rs2_val,
	input exec_pkg::word imm,
	input exec_pkg::exec_op_t op,
	input exec_pkg::word pc,
	output logic result_valid,
	output logic wr_en,
	output exec_pkg::word alu_result,
	output exec_pkg::word rs2_val_out,
	output exec_pkg::reg_addr_t rd_out,
	output exec_pkg::word pc_out,
	output exec_pkg::exec_op_t op_out
);

	stage_if u_stage_if();

	assign u_stage_if.decode_en = decode_en;
	assign u_stage_if.rd = rd;
	assign u_stage_if.rs1_val = rs1_val;
	assign u_stage_if.rs2_val = rs2_val;
	assign u_stage_if.imm = imm;
	assign u_stage_if.op = op;
	assign u_stage_if.pc = pc;

	execute_stage u_execute_stage
	(
		.clk(clk),
		.rst(rst),
		.issue(u_stage_if.sink),
		.result_valid(result_valid),
		.wr_en(wr_en),
		.alu_result(alu_result),
		.rs2_val_out(rs2_val_out),
		.rd_out(rd_out),
		.pc_out(pc_out),
		.op_out(op_out)
	);

endmodule

// File: testbench/exec_vectors.svh
// Directed execute vectors
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// Columns are op, rs1, rs2, imm, pc, rd, expected result, expected wr_en
localparam int n_vectors = 32;

vec_t vectors [n_vectors] = '{
	'{op_add, 64'h7fff_ffff_ffff_ffff, 64'd1, '0, '0, 5'd1, 64'h8000_0000_0000_0000, 1'b1},
	'{op_sub, 64'd5, 64'd7, '0, '0, 5'd2, -64'd2, 1'b1},
	'{op_sll, 64'h1234_5678_9abc_def0, 64'd0, '0, '0, 5'd3, 64'h1234_5678_9abc_def0, 1'b1},
	'{op_sll, 64'd1, 64'd63, '0, '0, 5'd4, 64'h8000_0000_0000_0000, 1'b1},
	'{op_srl, 64'h8000_0000_0000_0000, 64'd63, '0, '0, 5'd5, 64'd1, 1'b1},
	'{op_srai, 64'h8000_0000_0000_0000, '0, 64'd63, '0, 5'd6, '1, 1'b1},
	'{op_slt, -64'd1, 64'd1, '0, '0, 5'd7, 64'd1, 1'b1},
	'{op_sltiu, 64'd5, '0, -64'd3, '0, 5'd8, 64'd1, 1'b1},
	'{op_xori, 64'h00ff_00ff_00ff_00ff, '0, '1, '0, 5'd9, 64'hff00_ff00_ff00_ff00, 1'b1},
	'{op_and, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, '0, '0, 5'd10,
		64'h0f00_0f00_0f00_0f00, 1'b1},
	'{op_lui, '0, '0, 64'hffff_ffff_8000_0000, '0, 5'd11, 64'hffff_ffff_8000_0000, 1'b1},
	'{op_auipc, '0, '0, 64'hffff_ffff_ffff_f000, 64'h8000_1000, 5'd12, 64'h8000_0000, 1'b1},
	'{op_addw, 64'h7fff_ffff, 64'd1, '0, '0, 5'd13, 64'hffff_ffff_8000_0000, 1'b1},
	'{op_sllw, 64'd1, 64'd31, '0, '0, 5'd14, 64'hffff_ffff_8000_0000, 1'b1},
	'{op_sraw, 64'h8000_0000, 64'h24, '0, '0, 5'd15, 64'hffff_ffff_f800_0000, 1'b1}, // Shift 4
	'{op_mul, -64'd3, 64'd7, '0, '0, 5'd16, -64'd21, 1'b1},
	'{op_mulh, 64'h8000_0000_0000_0000, 64'd2, '0, '0, 5'd17, '1, 1'b1},
	'{op_mulhsu, '1, '1, '0, '0, 5'd18, '1, 1'b1},
	'{op_mulhu, '1, '1, '0, '0, 5'd19, -64'd2, 1'b1},
	'{op_mulw, 64'h1_0000, 64'h8000, '0, '0, 5'd20, 64'hffff_ffff_8000_0000, 1'b1},
	'{op_div, -64'd7, 64'd2, '0, '0, 5'd21, -64'd3, 1'b1},
	'{op_rem, -64'd7, 64'd2, '0, '0, 5'd22, '1, 1'b1},
	'{op_divu, -64'd7, 64'd2, '0, '0, 5'd23, 64'h7fff_ffff_ffff_fffc, 1'b1},
	'{op_remu, -64'd7, 64'd2, '0, '0, 5'd0, 64'd1, 1'b1},
	'{op_div, 64'd123, '0, '0, '0, 5'd24, '1, 1'b1}, // Divide by zero
	'{op_rem, 64'd123, '0, '0, '0, 5'd25, 64'd123, 1'b1},
	'{op_div, 64'h8000_0000_0000_0000, '1, '0, '0, 5'd26, 64'h8000_0000_0000_0000, 1'b1},
	'{op_rem, 64'h8000_0000_0000_0000, '1, '0, '0, 5'd27, 64'd0, 1'b1},
	'{op_divw, 64'h1234_5678_ffff_fff9, 64'd2, '0, '0, 5'd28, -64'd3, 1'b1},
	'{op_remuw, -64'd7, 64'h10, '0, '0, 5'd29, 64'd9, 1'b1},
	'{op_remw, 64'hffff_fff9, 64'hffff_ffff_0000_0000, '0, '0, 5'd30, -64'd7, 1'b1},
	'{op_pass, 64'h55, 64'hdead_beef_0000_0001, 64'h10, 64'h1000, 5'd31, '0, 1'b0}
};

`endif

// File: testbench/tb_exec_top.sv
// Execute stage testbench
`timescale 1ns/100ps

module tb_exec_top;
	import exec_pkg::*;

	typedef struct packed
	{
		exec_op_t op;
		word rs1;
		word rs2;
		word imm;
		word pc;
		reg_addr_t rd;
		word exp;
		logic exp_wr;
	} vec_t;

	`include "exec_vectors.svh"

	localparam int period = 40;
	localparam int n_random = 200;

	logic clk;
	logic rst;
	logic decode_en;
	reg_addr_t rd;
	word rs1_val;
	word rs2_val;
	word imm;
	exec_op_t op;
	word pc;
	logic result_valid;
	logic wr_en;
	word alu_result;
	word rs2_val_out;
	reg_addr_t rd_out;
	word pc_out;
	exec_op_t op_out;
	integer seed;

	exec_top u_exec_top (.*);

	always #(period / 2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_word(input string name, input word exp, input word act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_op(input string name, input exec_op_t exp, input exec_op_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %s, actual %s", name, exp.name(), act.name()));
	endtask

	task automatic drive_issue(input logic en, input exec_op_t d_op, input word a, input word b,
		input word i, input word p, input reg_addr_t r);
		decode_en = en;
		op = d_op;
		rs1_val = a;
		rs2_val = b;
		imm = i;
		pc = p;
		rd = r;
	endtask

	// Reference results for the random instruction mix
	function automatic word ref_result(input exec_op_t f_op, input word a, input word b);
		logic [31:0] sum_w;
		sum_w = a[31:0] + b[31:0];
		case (f_op)
			op_add: return a + b;
			op_xor: return a ^ b;
			op_sltu: return (a < b) ? 64'd1 : 64'd0;
			default: return {{32{sum_w[31]}}, sum_w}; // addw
		endcase
	endfunction

	initial
	begin
		#((n_vectors + n_random + 20) * period);
		abort_run("Timeout: the testbench did not finish in the expected time");
	end

	initial
	begin
		vec_t v;
		exec_op_t r_op;
		logic [31:0] rnd;
		string name;
		word a;
		word b;
		word last_res;
		clk = 1'b0;
		rst = 1'b1;
		seed = 32'h3e7f;
		last_res = '0;
		drive_issue(1'b0, op_nop, '0, '0, '0, '0, '0);
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		check_bit("reset valid", 1'b0, result_valid);
		check_bit("reset wr_en", 1'b0, wr_en);
		@(posedge clk);
		#2;
		check_bit("idle valid", 1'b0, result_valid);
		check_bit("idle wr_en", 1'b0, wr_en);

		for (int i = 0; i < n_vectors; i++)
		begin
			v = vectors[i];
			r_op = v.op;
			name = $sformatf("vec%0d_%s", i, r_op.name());
			drive_issue(1'b1, v.op, v.rs1, v.rs2, v.imm, v.pc, v.rd);
			@(posedge clk);
			#2; // One cycle latency
			check_bit({name, " valid"}, 1'b1, result_valid);
			check_bit({name, " wr_en"}, v.exp_wr, wr_en);
			check_word(name, v.exp, alu_result);
			check_word({name, " rs2"}, v.rs2, rs2_val_out);
			check_word({name, " pc"}, v.pc, pc_out);
			check_addr({name, " rd"}, v.rd, rd_out);
			check_op({name, " op"}, v.op, op_out);
			last_res = v.exp;
		end

		for (int n = 0; n < n_random; n++)
		begin
			rnd = $random(seed);
			case (rnd[2:1])
				2'd0: r_op = op_add;
				2'd1: r_op = op_xor;
				2'd2: r_op = op_sltu;
				default: r_op = op_addw;
			endcase
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			name = $sformatf("rand%0d_%s", n, r_op.name());
			drive_issue(rnd[0], r_op, a, b, '0, {$random(seed), $random(seed)}, rnd[7:3]);
			@(posedge clk);
			#2;
			check_bit({name, " valid"}, rnd[0], result_valid);
			check_bit({name, " wr_en"}, rnd[0], wr_en);
			if (rnd[0])
			begin
				last_res = ref_result(r_op, a, b);
				check_word(name, last_res, alu_result);
			end
			else
				check_word({name, " hold"}, last_res, alu_result); // Idle cycle keeps old data
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: compile.f
+incdir+testbench
hw/exec_pkg.sv
hw/stage_if.sv
hw/int_alu.sv
hw/mul_div_unit.sv
hw/execute_stage.sv
hw/exec_top.sv
testbench/tb_exec_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_exec_top -o sim_exec
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_exec > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
